// File: sim.f
source/ooo_pkg.sv
source/commit_if.sv
source/regstat.sv
source/rob_tags.sv
source/arch_regfile.sv
source/issue_ctrl.sv
source/rename_stage.sv
sim/rename_props.sv
sim/rename_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module rename_tb -Mdir obj_dir \
    && ./obj_dir/Vrename_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

// File: sim/rename_tb.sv
// *********************************************************
// rename stage testbench
// table of issue, commit and flush rows checked against a
// reference model of tags, busy table and registers
// *********************************************************

`timescale 1ns/1ps

module rename_tb
    import ooo_pkg::*;
();

    localparam int MAX_ROWS = 48;
    localparam int ROW_CYCLES = 20;  // worst handshake incl. back-pressure wait

    logic clk, reset, flush, issue_req, rd_writes, issue_ack;
    reg_idx_t rs1, rs2, rd, commit_dest;
    logic commit_valid, commit_reg_write;
    rob_tag_t commit_tag, issue_tag, src1_tag, src2_tag;
    xlen_t commit_value, src1_value, src2_value;
    logic src1_busy, src2_busy;

    // op codes are 0 issue, 1 commit oldest, 2 flush and 3 issue into a full ring
    int       row_op [MAX_ROWS];
    reg_idx_t row_rs1 [MAX_ROWS];
    reg_idx_t row_rs2 [MAX_ROWS];
    reg_idx_t row_rd [MAX_ROWS];
    logic     row_flag [MAX_ROWS];  // rd_writes for issues and reg_write for commits
    int       n_rows;

    // reference model
    rob_tag_t next_tag;
    rob_tag_t q_tag [$];  // in-flight tags with the oldest first
    reg_idx_t q_rd [$];
    logic     q_wr [$];
    logic     ref_busy [NUM_REGS];
    rob_tag_t ref_tag [NUM_REGS];
    xlen_t    ref_regs [NUM_REGS];

    int seed = 7917;
    int errors, row_err, cycles, timeout_limit;

    rename_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ends the run when a handshake never completes
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            $display("timeout: handshake did not complete after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic add_row(input int op, input int a, input int b, input int d, input logic f);
        row_op[n_rows]   = op;
        row_rs1[n_rows]  = reg_idx_t'(a);
        row_rs2[n_rows]  = reg_idx_t'(b);
        row_rd[n_rows]   = reg_idx_t'(d);
        row_flag[n_rows] = f;
        n_rows++;
    endtask

    task automatic check_val(input string what, input xlen_t got, input xlen_t exp);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
            row_err++;
        end
    endtask

    task automatic commit_oldest(input logic reg_write);
        rob_tag_t t;
        reg_idx_t d;
        logic     w;
        xlen_t    v;
        if (q_tag.size() == 0) begin
            $display("table error: commit requested with nothing in flight");
            row_err++;
        end else begin
            t = q_tag.pop_front();
            d = q_rd.pop_front();
            w = q_wr.pop_front() && reg_write;
            v = $random(seed);
            @(posedge clk);
            commit_valid     <= 1'b1;
            commit_tag       <= t;
            commit_dest      <= d;
            commit_value     <= v;
            commit_reg_write <= w;
            @(posedge clk);
            commit_valid <= 1'b0;
            if (w && d != '0) begin
                ref_regs[d] = v;
                if (ref_busy[d] && ref_tag[d] == t) ref_busy[d] = 1'b0;  // newest writer only
            end
        end
    endtask

    task automatic issue_one(input int r, input logic blocked);
        reg_idx_t a, b;
        @(posedge clk);
        issue_req <= 1'b1;
        rs1       <= row_rs1[r];
        rs2       <= row_rs2[r];
        rd        <= row_rd[r];
        rd_writes <= row_flag[r];
        if (blocked) begin
            repeat (6) begin
                @(negedge clk);
                assert (!issue_ack) else begin
                    $display("issue was acknowledged while all tags were in flight");
                    row_err++;
                end
            end
            commit_oldest(1'b1);  // frees the head tag
        end
        do @(negedge clk); while (!issue_ack);
        a = row_rs1[r];
        b = row_rs2[r];
        check_val("issue_tag", xlen_t'(issue_tag), xlen_t'(next_tag));
        check_val("src1_busy", xlen_t'(src1_busy), xlen_t'(ref_busy[a]));
        check_val("src1_tag", xlen_t'(src1_tag), ref_busy[a] ? xlen_t'(ref_tag[a]) : '0);
        check_val("src1_value", src1_value, ref_busy[a] ? '0 : ref_regs[a]);
        check_val("src2_busy", xlen_t'(src2_busy), xlen_t'(ref_busy[b]));
        check_val("src2_tag", xlen_t'(src2_tag), ref_busy[b] ? xlen_t'(ref_tag[b]) : '0);
        check_val("src2_value", src2_value, ref_busy[b] ? '0 : ref_regs[b]);
        if (row_flag[r] && row_rd[r] != '0) begin
            ref_busy[row_rd[r]] = 1'b1;
            ref_tag[row_rd[r]]  = next_tag;
        end
        q_tag.push_back(next_tag);
        q_rd.push_back(row_rd[r]);
        q_wr.push_back(row_flag[r]);
        next_tag = next_tag + 4'd1;  // wraps with the ring
        @(posedge clk);
        issue_req <= 1'b0;
        do @(negedge clk); while (issue_ack);
    endtask

    task automatic flush_all();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int j = 0; j < NUM_REGS; j++) ref_busy[j] = 1'b0;
        q_tag.delete();
        q_rd.delete();
        q_wr.delete();
        next_tag = '0;
    endtask

    initial begin
        issue_req = 1'b0;
        rd_writes = 1'b0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        commit_valid = 1'b0;
        commit_tag = '0;
        commit_dest = '0;
        commit_value = '0;
        commit_reg_write = 1'b0;
        flush = 1'b0;
        reset = 1'b1;
        errors = 0;
        n_rows = 0;
        timeout_limit = 0;
        next_tag = '0;
        for (int j = 0; j < NUM_REGS; j++) begin
            ref_busy[j] = 1'b0;
            ref_tag[j]  = '0;
            ref_regs[j] = '0;
        end
        add_row(0, 1, 2, 3, 1);    // independent issue gets tag 0
        add_row(0, 3, 0, 4, 1);    // raw on x3
        add_row(0, 5, 6, 3, 1);    // x3 renamed again
        add_row(1, 0, 0, 0, 1);    // older x3 writer so x3 stays busy
        add_row(0, 3, 4, 0, 1);    // rd x0 never busy
        add_row(1, 0, 0, 0, 1);
        add_row(1, 0, 0, 0, 1);    // newest x3 writer clears it
        add_row(1, 0, 0, 0, 1);
        add_row(0, 3, 4, 7, 0);    // rd_writes low
        add_row(0, 7, 0, 0, 0);
        add_row(1, 0, 0, 0, 0);
        add_row(1, 0, 0, 0, 1);
        for (int i = 0; i < NUM_TAGS; i++) begin
            add_row(0, $random(seed) & 31, $random(seed) & 31, 8 + i, 1);  // fill the ring
        end
        add_row(3, 9, 3, 2, 1);    // waits for a free tag
        add_row(2, 0, 0, 0, 0);
        add_row(0, 3, 4, 3, 1);    // tag 0 again and committed values kept
        add_row(0, 3, 9, 5, 1);    // x9 was busy before the flush
        add_row(1, 0, 0, 0, 1);
        add_row(0, 3, 5, 0, 0);
        timeout_limit = n_rows * ROW_CYCLES + 50;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            row_err = 0;
            case (row_op[r])
                0: issue_one(r, 1'b0);
                1: commit_oldest(row_flag[r]);
                2: flush_all();
                default: issue_one(r, 1'b1);
            endcase
            errors += row_err;
            $display("row %0d op %0d: %s", r, row_op[r], (row_err == 0) ? "ok" : "failed");
        end
        repeat (2) @(posedge clk);
        $display("rows %0d, errors %0d", n_rows, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim/rename_props.sv
// *********************************************************
// rename stage properties
// handshake order, result stability and x0 never busy
// *********************************************************

`timescale 1ns/1ps

module rename_props
    import ooo_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     issue_req,
    input logic     issue_ack,
    input reg_idx_t rs1,
    input reg_idx_t rs2,
    input rob_tag_t issue_tag,
    input logic     src1_busy,
    input rob_tag_t src1_tag,
    input xlen_t    src1_value,
    input logic     src2_busy,
    input rob_tag_t src2_tag,
    input xlen_t    src2_value
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(issue_ack) |-> issue_req)
        else $error("issue_ack rose without issue_req");

    // results held for the whole ack phase
    results_stable: assert property (@(posedge clk) disable iff (reset)
        issue_ack && $past(issue_ack) |->
            $stable({issue_tag, src1_busy, src1_tag, src1_value,
                     src2_busy, src2_tag, src2_value}))
        else $error("results changed while issue_ack high");

    x0_never_busy: assert property (@(posedge clk) disable iff (reset)
        issue_ack |-> !(rs1 == '0 && src1_busy) && !(rs2 == '0 && src2_busy))
        else $error("register 0 reported busy");

endmodule

bind rename_stage rename_props props_i (.*);

// File: source/rename_stage.sv
// *********************************************************
// rename and issue stage
// status table, tag allocator and register file behind a
// four-phase issue handshake and a commit strobe
// *********************************************************

`timescale 1ns/1ps

module rename_stage
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     issue_req,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     rd_writes,
    output logic     issue_ack,
    input  logic     commit_valid,
    input  rob_tag_t commit_tag,
    input  reg_idx_t commit_dest,
    input  xlen_t    commit_value,
    input  logic     commit_reg_write,
    output rob_tag_t issue_tag,
    output logic     src1_busy,
    output rob_tag_t src1_tag,
    output xlen_t    src1_value,
    output logic     src2_busy,
    output rob_tag_t src2_tag,
    output xlen_t    src2_value
);

    commit_if commit_bus ();

    logic     alloc;
    rob_tag_t alloc_tag;
    logic     tags_free;
    logic     issue_we;
    logic     lk1_busy;   // raw status table lookup
    rob_tag_t lk1_tag;
    logic     lk2_busy;
    rob_tag_t lk2_tag;
    xlen_t    rdata_a;
    xlen_t    rdata_b;

    // rob commit pins onto the shared bus
    assign commit_bus.commit_valid     = commit_valid;
    assign commit_bus.commit_tag       = commit_tag;
    assign commit_bus.commit_dest      = commit_dest;
    assign commit_bus.commit_value     = commit_value;
    assign commit_bus.commit_reg_write = commit_reg_write;

    regstat u_regstat (
        .clk, .reset, .flush, .rs1, .rs2,
        .issue_dest(rd), .issue_we, .issue_tag(alloc_tag), .commit(commit_bus),
        .src1_busy(lk1_busy), .src2_busy(lk2_busy), .src1_tag(lk1_tag), .src2_tag(lk2_tag)
    );

    rob_tags u_rob_tags (
        .clk, .reset, .flush, .alloc, .commit(commit_bus), .alloc_tag, .tags_free
    );

    arch_regfile u_arch_regfile (
        .clk, .reset, .ra(rs1), .rb(rs2), .commit(commit_bus), .rdata_a, .rdata_b
    );

    issue_ctrl u_issue_ctrl (
        .clk, .reset, .flush, .issue_req, .rd_writes, .rs1, .rs2, .rd, .issue_ack,
        .rs1_busy(lk1_busy), .rs1_tag(lk1_tag), .rs2_busy(lk2_busy), .rs2_tag(lk2_tag),
        .rs1_value(rdata_a), .rs2_value(rdata_b), .commit(commit_bus),
        .tags_free, .alloc_tag, .alloc, .issue_we, .issue_tag,
        .src1_busy, .src1_tag, .src1_value, .src2_busy, .src2_tag, .src2_value
    );

endmodule

// File: source/issue_ctrl.sv
// *********************************************************
// issue control
// four-phase req/ack FSM, tag allocation, operand select
// with forwarding of a commit that lands during lookup
// *********************************************************

`timescale 1ns/1ps

module issue_ctrl
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     issue_req,
    input  logic     rd_writes,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    output logic     issue_ack,
    input  logic     rs1_busy,    // status table lookup
    input  rob_tag_t rs1_tag,
    input  logic     rs2_busy,
    input  rob_tag_t rs2_tag,
    input  xlen_t    rs1_value,   // register file read
    input  xlen_t    rs2_value,
    commit_if.sink   commit,
    input  logic     tags_free,
    input  rob_tag_t alloc_tag,
    output logic     alloc,
    output logic     issue_we,
    output rob_tag_t issue_tag,
    output logic     src1_busy,
    output rob_tag_t src1_tag,
    output xlen_t    src1_value,
    output logic     src2_busy,
    output rob_tag_t src2_tag,
    output xlen_t    src2_value
);

    issue_state_t state_q;
    logic         in_lookup;
    logic         fwd1;       // producer of rs1 commits right now
    logic         fwd2;
    logic         wait1;      // rs1 still waits on a producer
    logic         wait2;

    assign in_lookup = (state_q == lookup);

    // the tag is taken and rd renamed in the lookup cycle only
    assign alloc    = in_lookup;
    assign issue_we = in_lookup && rd_writes && (rd != '0);

    // the status table still shows busy for a producer committing this
    // cycle, so take its value straight off the commit bus
    assign fwd1 = commit.commit_valid && commit.commit_reg_write && rs1_busy
               && (commit.commit_tag == rs1_tag) && (commit.commit_dest == rs1);
    assign fwd2 = commit.commit_valid && commit.commit_reg_write && rs2_busy
               && (commit.commit_tag == rs2_tag) && (commit.commit_dest == rs2);

    assign wait1 = rs1_busy && !fwd1;
    assign wait2 = rs2_busy && !fwd2;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state_q   <= idle;
            issue_ack <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    if (issue_req && tags_free) begin  // full ring holds us here
                        state_q <= lookup;
                    end
                end
                lookup: begin
                    issue_ack <= 1'b1;  // results registered on this edge
                    state_q   <= ack_high;
                end
                ack_high: begin
                    if (!issue_req) begin
                        issue_ack <= 1'b0;
                        state_q   <= wait_low;
                    end
                end
                wait_low: state_q <= idle;  // turnaround before next request
                default:  state_q <= idle;
            endcase
        end
    end

    // results, loaded once per handshake and held while ack is up
    always_ff @(posedge clk) begin
        if (in_lookup) begin
            issue_tag  <= alloc_tag;
            src1_busy  <= wait1;
            src1_tag   <= wait1 ? rs1_tag : '0;
            src1_value <= fwd1 ? commit.commit_value : (rs1_busy ? '0 : rs1_value);
            src2_busy  <= wait2;
            src2_tag   <= wait2 ? rs2_tag : '0;
            src2_value <= fwd2 ? commit.commit_value : (rs2_busy ? '0 : rs2_value);
        end
    end

endmodule

// File: source/arch_regfile.sv
// *********************************************************
// architectural register file
// 32 committed registers written at commit, x0 reads zero
// *********************************************************

`timescale 1ns/1ps

module arch_regfile
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,    // zeroes every register
    input  reg_idx_t ra,
    input  reg_idx_t rb,
    commit_if.sink   commit,
    output xlen_t    rdata_a,
    output xlen_t    rdata_b
);

    xlen_t regs [NUM_REGS];
    logic  we;

    // only committed results reach this file, flush leaves it alone
    assign we = commit.commit_valid && commit.commit_reg_write
             && (commit.commit_dest != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int j = 0; j < NUM_REGS; j++) begin
                regs[j] <= '0;
            end
        end else if (we) begin
            regs[commit.commit_dest] <= commit.commit_value;
        end
    end

    // read ports, value written at an edge is seen the cycle after
    always_comb begin
        rdata_a = (ra == '0) ? '0 : regs[ra];  // x0 hardwired
        rdata_b = (rb == '0) ? '0 : regs[rb];
    end

endmodule

// File: source/rob_tags.sv
// *********************************************************
// rob tag allocator
// hands out tags in ring order at issue and takes them back
// in order as the rob commits
// *********************************************************

`timescale 1ns/1ps

module rob_tags
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,      // mispredict, every tag in flight is dropped
    input  logic     alloc,      // one tag taken this cycle
    commit_if.sink   commit,
    output rob_tag_t alloc_tag,  // next tag to be handed out
    output logic     tags_free   // at least one tag available
);

    rob_tag_t   head_q;   // oldest tag in flight
    rob_tag_t   tail_q;   // next tag to allocate
    tag_count_t count_q;  // tags in flight
    logic       free;
    logic       do_alloc;

    // commits arrive in order, so the committing tag must be the head
    // a stray commit with another tag or on an empty ring is ignored
    assign free = commit.commit_valid && (count_q != '0)
               && (commit.commit_tag == head_q);

    // never allocate past a full ring
    assign do_alloc = alloc && tags_free;

    assign alloc_tag = tail_q;
    assign tags_free = (count_q != tag_count_t'(NUM_TAGS));

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_alloc) begin
                tail_q <= tail_q + 1'b1;  // wraps modulo NUM_TAGS
            end
            if (free) begin
                head_q <= head_q + 1'b1;
            end
            // alloc and free can land in the same cycle
            case ({do_alloc, free})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: source/regstat.sv
// *********************************************************
// register status table
// busy bit and producer tag per architectural register, set
// at issue and cleared when the newest writer commits
// *********************************************************

`timescale 1ns/1ps

module regstat
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,       // branch recovery, drops every busy bit
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t issue_dest,
    input  logic     issue_we,    // issued instruction renames issue_dest
    input  rob_tag_t issue_tag,   // tag just handed out
    commit_if.sink   commit,
    output logic     src1_busy,
    output logic     src2_busy,
    output rob_tag_t src1_tag,
    output rob_tag_t src2_tag
);

    logic [NUM_REGS-1:0] busy_q;          // bit 0 never gets set
    rob_tag_t            tag_q [NUM_REGS];
    logic [NUM_REGS-1:0] set_vec;         // one-hot issue write
    logic [NUM_REGS-1:0] clr_vec;         // one-hot commit clear
    logic                clear_ok;

    // a commit only frees the register if it is still the newest writer
    // and the same register is not being renamed again this cycle
    assign clear_ok = commit.commit_valid && commit.commit_reg_write
                   && (tag_q[commit.commit_dest] == commit.commit_tag)
                   && !(issue_we && (issue_dest == commit.commit_dest));

    // decoders, x0 never selected
    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        if (issue_we && (issue_dest != '0)) begin
            set_vec[issue_dest] = 1'b1;
        end
        if (clear_ok && (commit.commit_dest != '0)) begin
            clr_vec[commit.commit_dest] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q | set_vec) & ~clr_vec;  // set and clear never hit one reg
        end
    end

    // producer tags
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int j = 0; j < NUM_REGS; j++) begin
                tag_q[j] <= '0;
            end
        end else begin
            for (int j = 1; j < NUM_REGS; j++) begin
                if (set_vec[j]) begin
                    tag_q[j] <= issue_tag;
                end
            end
        end
    end

    // lookup ports, combinational
    // a register that is not busy reports tag 0, so x0 reads idle with tag 0
    always_comb begin
        src1_busy = busy_q[rs1];
        src2_busy = busy_q[rs2];
        src1_tag  = busy_q[rs1] ? tag_q[rs1] : '0;
        src2_tag  = busy_q[rs2] ? tag_q[rs2] : '0;
    end

endmodule

// File: source/commit_if.sv
// *********************************************************
// commit bus
// in-order commit strobe from the rob with its payload
// *********************************************************

`timescale 1ns/1ps

interface commit_if
    import ooo_pkg::*;
();

    logic     commit_valid;      // one cycle per committed instruction
    rob_tag_t commit_tag;        // always the oldest tag in flight
    reg_idx_t commit_dest;
    xlen_t    commit_value;
    logic     commit_reg_write;  // instruction writes commit_dest

    // rob side
    modport source (
        output commit_valid, commit_tag, commit_dest, commit_value, commit_reg_write
    );

    // every consumer of the commit
    modport sink (
        input commit_valid, commit_tag, commit_dest, commit_value, commit_reg_write
    );

endinterface

// File: source/ooo_pkg.sv
// *********************************************************
// ooo package
// widths, typedefs and the issue FSM states shared by the
// rename/issue stage and its testbench
// *********************************************************

package ooo_pkg;

    // architectural register file size
    localparam int NUM_REGS = 32;

    // reorder buffer tags that can be in flight at once
    localparam int NUM_TAGS = 16;

    localparam int REG_IDX_W = $clog2(NUM_REGS);  // 5 bits
    localparam int TAG_W = $clog2(NUM_TAGS);      // 4 bits
    localparam int TAG_CNT_W = $clog2(NUM_TAGS + 1);  // count has to reach NUM_TAGS
    localparam int XLEN = 32;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;    // register index
    typedef logic [TAG_W-1:0] rob_tag_t;        // rob entry number
    typedef logic [TAG_CNT_W-1:0] tag_count_t;  // tags in flight, 0..NUM_TAGS
    typedef logic [XLEN-1:0] xlen_t;            // data word

    // four-phase issue handshake
    //   idle      waiting for issue_req and a free tag
    //   lookup    tag allocated, status table read, results registered
    //   ack_high  issue_ack up until issue_req drops
    //   wait_low  ack dropped, one turnaround cycle back to idle
    typedef enum logic [1:0] {
        idle,
        lookup,
        ack_high,
        wait_low
    } issue_state_t;

endpackage
